// File: verilog/sd_settings.svh
`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

// ========================================
// Command frame layout
// ========================================

// Full command or response frame on the CMD line
`define SD_FRAME_BITS       48

// CRC7 field width
`define SD_CRC_BITS         7

// Start bit, direction, index and argument are covered by the CRC
`define SD_CRC_COVER_BITS   40

// ========================================
// Card clock and response timing
// ========================================

// Half periods in clk_fast cycles, slow value shortened for simulation
`define SD_SLOW_HALF        8
`define SD_FAST_HALF        2

// Card clock rising edges to wait for a response start bit
`define SD_RESP_TIMEOUT     64

`endif

// File: verilog/sd_clk_pkg.sv
package sd_clk_pkg;

    // Card clock rate as held by the configuration block
    //   speed_off parks the card clock low
    typedef enum logic [1:0] {
        speed_off  = 2'd0,
        speed_slow = 2'd1,
        speed_fast = 2'd2
    } clk_speed_t;

endpackage

// File: verilog/sd_cmd_pkg.sv
`include "sd_settings.svh"

package sd_cmd_pkg;

    // ========================================
    // CMD line frame
    // ========================================

    // Field view, first member is the first bit on the line
    typedef struct packed {
        logic                    start;
        logic                    dir;
        logic [5:0]              index;
        logic [31:0]             arg;
        logic [`SD_CRC_BITS-1:0] crc;
        logic                    stop;
    } sd_frame_fields_t;

    // Same word seen as fields or as a shift register
    typedef union packed {
        logic [`SD_FRAME_BITS-1:0] raw;
        sd_frame_fields_t          fields;
    } sd_frame_u;

    // ========================================
    // Response result
    // ========================================

    // CRC error wins over end-bit error when both are present
    typedef enum logic [1:0] {
        resp_ok      = 2'd0,
        resp_crc_err = 2'd1,
        resp_end_err = 2'd2,
        resp_timeout = 2'd3
    } resp_status_t;

endpackage

// File: verilog/sd_crc7.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_crc7 (
    input  logic                    clk_fast,
    input  logic                    arst_n,
    input  logic                    clear,
    input  logic                    shift,
    input  logic                    din,
    output logic [`SD_CRC_BITS-1:0] crc
);
    // x^7 + x^3 + 1, the x^7 term is the feedback
    localparam logic [`SD_CRC_BITS-1:0] crc_poly = 7'h09;

    logic feedback;

    assign feedback = din ^ crc[`SD_CRC_BITS-1];

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift) begin
            crc <= {crc[`SD_CRC_BITS-2:0], 1'b0} ^ (feedback ? crc_poly : '0);
        end
    end

endmodule

// File: verilog/sd_clk_config.sv
`timescale 1ns/1ps

module sd_clk_config (
    input  logic                   clk_fast,
    input  logic                   arst_n,
    input  logic                   cfg_req,
    input  sd_clk_pkg::clk_speed_t cfg_speed,
    output logic                   cfg_ack,
    input  logic                   clk_idle,
    output sd_clk_pkg::clk_speed_t speed
);
    import sd_clk_pkg::*;

    // Run also covers holding the ack until the request drops
    typedef enum logic [1:0] {
        cfg_run,
        cfg_stop,
        cfg_load
    } cfg_state_t;

    cfg_state_t state;

    // ========================================
    // Speed change sequencer
    // ========================================
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state   <= cfg_run;
            speed   <= speed_slow;
            cfg_ack <= 1'b0;
        end else begin
            case (state)
            cfg_run: begin
                if (!cfg_req) begin
                    cfg_ack <= 1'b0;
                end else if (!cfg_ack) begin
                    // Park the card clock before touching the divisor
                    speed <= speed_off;
                    state <= cfg_stop;
                end
            end

            cfg_stop: begin
                if (clk_idle) begin
                    state <= cfg_load;
                end
            end

            cfg_load: begin
                speed   <= cfg_speed;
                cfg_ack <= 1'b1;
                state   <= cfg_run;
            end

            default: begin
                state <= cfg_run;
            end
            endcase
        end
    end

    // Requested speed must not move until it has been taken
    a_cfg_speed_stable: assert property (
        @(posedge clk_fast) disable iff (!arst_n)
        (cfg_req && !cfg_ack) |=> $stable(cfg_speed)
    );

endmodule

// File: verilog/sd_clk_gen.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_clk_gen (
    input  logic                   clk_fast,
    input  logic                   arst_n,
    input  sd_clk_pkg::clk_speed_t speed,
    output logic                   sd_clk,
    output logic                   sd_rise,
    output logic                   sd_fall,
    output logic                   clk_idle
);
    import sd_clk_pkg::*;

    localparam int cnt_w = $clog2(`SD_SLOW_HALF);

    logic [cnt_w-1:0] half_cnt;
    logic [cnt_w-1:0] reload;
    logic             running;
    logic             expire;

    // Half period length for the selected speed
    assign reload = (speed == speed_fast) ? cnt_w'(`SD_FAST_HALF - 1)
                                          : cnt_w'(`SD_SLOW_HALF - 1);

    // A started high phase always completes, so the clock only parks low
    assign running  = (speed != speed_off) || sd_clk;
    assign expire   = running && (half_cnt == '0);
    assign clk_idle = (speed == speed_off) && !sd_clk;

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            half_cnt <= '0;
            sd_clk   <= 1'b0;
            sd_rise  <= 1'b0;
            sd_fall  <= 1'b0;
        end else begin
            // Strobes line up with the cycle where sd_clk has just moved
            sd_rise <= expire && !sd_clk;
            sd_fall <= expire && sd_clk;
            if (expire) begin
                sd_clk   <= !sd_clk;
                half_cnt <= reload;
            end else if (running) begin
                half_cnt <= half_cnt - 1'b1;
            end else begin
                half_cnt <= '0;
            end
        end
    end

    a_strobe_excl: assert property (
        @(posedge clk_fast) disable iff (!arst_n)
        !(sd_rise && sd_fall)
    );

endmodule

// File: verilog/sd_cmd_tx.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_cmd_tx (
    input  logic                     clk_fast,
    input  logic                     arst_n,
    input  logic                     sd_fall,
    input  logic                     cmd_req,
    input  logic [5:0]               cmd_index,
    input  logic [31:0]              cmd_arg,
    input  logic                     cmd_resp_exp,
    output logic                     cmd_ack,
    output logic                     cmd_out,
    output logic                     cmd_oe,
    output logic                     rx_start,
    input  logic                     rx_done,
    input  sd_cmd_pkg::sd_frame_u    rx_frame,
    input  sd_cmd_pkg::resp_status_t rx_status,
    output logic [5:0]               resp_index,
    output logic [31:0]              resp_arg,
    output sd_cmd_pkg::resp_status_t resp_status
);
    import sd_cmd_pkg::*;

    typedef enum logic [1:0] {
        tx_idle,
        tx_send,
        tx_resp,
        tx_ack
    } tx_state_t;

    tx_state_t               state;
    sd_frame_u               frame;
    logic [5:0]              bit_cnt;
    logic [`SD_CRC_BITS-1:0] crc;
    logic                    start;
    logic                    shift_bit;
    logic                    frame_end;
    logic                    crc_shift;
    logic                    crc_load;

    assign start     = (state == tx_idle) && cmd_req;
    assign shift_bit = (state == tx_send) && sd_fall && (bit_cnt != 6'(`SD_FRAME_BITS));
    assign frame_end = (state == tx_send) && sd_fall && (bit_cnt == 6'(`SD_FRAME_BITS));
    assign crc_shift = shift_bit && (bit_cnt < 6'(`SD_CRC_COVER_BITS));

    sd_crc7 u_crc7 (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (start),
        .shift    (crc_shift),
        .din      (frame.raw[`SD_FRAME_BITS-1]),
        .crc      (crc)
    );

    // ========================================
    // Frame shift register
    // ========================================
    always_ff @(posedge clk_fast) begin
        if (start) begin
            frame.fields.start <= 1'b0;
            frame.fields.dir   <= 1'b1;
            frame.fields.index <= cmd_index;
            frame.fields.arg   <= cmd_arg;
            frame.fields.crc   <= '0;
            frame.fields.stop  <= 1'b1;
        end else if (crc_load) begin
            // After 40 shifts the CRC slot sits at the top of the word
            frame.raw[`SD_FRAME_BITS-1 -: `SD_CRC_BITS] <= crc;
        end else if (shift_bit) begin
            frame.raw <= {frame.raw[`SD_FRAME_BITS-2:0], 1'b1};
        end
    end

    // ========================================
    // Line control and handshake
    // ========================================
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state    <= tx_idle;
            bit_cnt  <= '0;
            cmd_out  <= 1'b1;
            cmd_oe   <= 1'b0;
            cmd_ack  <= 1'b0;
            rx_start <= 1'b0;
            crc_load <= 1'b0;
        end else begin
            rx_start <= 1'b0;
            crc_load <= 1'b0;
            case (state)
            tx_idle: begin
                if (start) begin
                    bit_cnt <= '0;
                    state   <= tx_send;
                end
            end

            tx_send: begin
                if (shift_bit) begin
                    cmd_oe   <= 1'b1;
                    cmd_out  <= frame.raw[`SD_FRAME_BITS-1];
                    bit_cnt  <= bit_cnt + 1'b1;
                    // CRC register is final one cycle after the last covered bit
                    crc_load <= (bit_cnt == 6'(`SD_CRC_COVER_BITS - 1));
                end else if (frame_end) begin
                    cmd_oe  <= 1'b0;
                    cmd_out <= 1'b1;
                    if (cmd_resp_exp) begin
                        rx_start <= 1'b1;
                        state    <= tx_resp;
                    end else begin
                        cmd_ack <= 1'b1;
                        state   <= tx_ack;
                    end
                end
            end

            tx_resp: begin
                if (rx_done) begin
                    cmd_ack <= 1'b1;
                    state   <= tx_ack;
                end
            end

            tx_ack: begin
                if (!cmd_req) begin
                    cmd_ack <= 1'b0;
                    state   <= tx_idle;
                end
            end
            endcase
        end
    end

    // Results stay put while cmd_ack is high
    always_ff @(posedge clk_fast) begin
        if ((state == tx_resp) && rx_done) begin
            resp_index  <= rx_frame.fields.index;
            resp_arg    <= rx_frame.fields.arg;
            resp_status <= rx_status;
        end else if (frame_end && !cmd_resp_exp) begin
            resp_index  <= '0;
            resp_arg    <= '0;
            resp_status <= resp_ok;
        end
    end

    a_oe_not_acked: assert property (
        @(posedge clk_fast) disable iff (!arst_n)
        cmd_ack |-> !cmd_oe
    );

endmodule

// File: verilog/sd_resp_rx.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_resp_rx (
    input  logic                     clk_fast,
    input  logic                     arst_n,
    input  logic                     sd_rise,
    input  logic                     cmd_in,
    input  logic                     rx_start,
    output logic                     rx_done,
    output sd_cmd_pkg::sd_frame_u    rx_frame,
    output sd_cmd_pkg::resp_status_t rx_status
);
    import sd_cmd_pkg::*;

    localparam int tmo_w = $clog2(`SD_RESP_TIMEOUT);

    typedef enum logic [1:0] {
        rx_idle,
        rx_wait,
        rx_capture,
        rx_check
    } rx_state_t;

    rx_state_t               state;
    logic [tmo_w-1:0]        tmo_cnt;
    logic [5:0]              bit_cnt;
    logic [`SD_CRC_BITS-1:0] crc;
    logic                    start_bit;
    logic                    take_bit;
    logic                    crc_shift;

    assign start_bit = (state == rx_wait) && sd_rise && !cmd_in;
    assign take_bit  = (state == rx_capture) && sd_rise;

    // Start bit counts as bit 0 of the covered range
    assign crc_shift = start_bit || (take_bit && (bit_cnt < 6'(`SD_CRC_COVER_BITS)));

    sd_crc7 u_crc7 (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .clear    (rx_start),
        .shift    (crc_shift),
        .din      (cmd_in),
        .crc      (crc)
    );

    // Response bits enter at the bottom, first bit ends up at the top
    always_ff @(posedge clk_fast) begin
        if (start_bit || take_bit) begin
            rx_frame.raw <= {rx_frame.raw[`SD_FRAME_BITS-2:0], cmd_in};
        end
    end

    // ========================================
    // Receive sequencer
    // ========================================
    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state     <= rx_idle;
            tmo_cnt   <= '0;
            bit_cnt   <= '0;
            rx_done   <= 1'b0;
            rx_status <= resp_ok;
        end else begin
            rx_done <= 1'b0;
            case (state)
            rx_idle: begin
                if (rx_start) begin
                    tmo_cnt <= '0;
                    state   <= rx_wait;
                end
            end

            // Hunt for the start bit, one edge at a time
            rx_wait: begin
                if (start_bit) begin
                    bit_cnt <= 6'd1;
                    state   <= rx_capture;
                end else if (sd_rise) begin
                    if (tmo_cnt == tmo_w'(`SD_RESP_TIMEOUT - 1)) begin
                        rx_status <= resp_timeout;
                        rx_done   <= 1'b1;
                        state     <= rx_idle;
                    end else begin
                        tmo_cnt <= tmo_cnt + 1'b1;
                    end
                end
            end

            rx_capture: begin
                if (take_bit) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 6'(`SD_FRAME_BITS - 1)) begin
                        state <= rx_check;
                    end
                end
            end

            rx_check: begin
                if (crc != rx_frame.fields.crc) begin
                    rx_status <= resp_crc_err;
                end else if (!rx_frame.fields.stop) begin
                    rx_status <= resp_end_err;
                end else begin
                    rx_status <= resp_ok;
                end
                rx_done <= 1'b1;
                state   <= rx_idle;
            end
            endcase
        end
    end

endmodule

// File: verilog/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host (
    input  logic                     clk_fast,
    input  logic                     arst_n,
    input  logic                     cfg_req,
    input  sd_clk_pkg::clk_speed_t   cfg_speed,
    output logic                     cfg_ack,
    input  logic                     cmd_req,
    input  logic [5:0]               cmd_index,
    input  logic [31:0]              cmd_arg,
    input  logic                     cmd_resp_exp,
    output logic                     cmd_ack,
    output logic [5:0]               resp_index,
    output logic [31:0]              resp_arg,
    output sd_cmd_pkg::resp_status_t resp_status,
    output logic                     sd_clk,
    output logic                     cmd_out,
    output logic                     cmd_oe,
    input  logic                     cmd_in
);
    import sd_clk_pkg::*;
    import sd_cmd_pkg::*;

    clk_speed_t   speed;
    logic         clk_idle;
    logic         sd_rise;
    logic         sd_fall;
    logic         rx_start;
    logic         rx_done;
    sd_frame_u    rx_frame;
    resp_status_t rx_status;

    // ========================================
    // Card clock
    // ========================================
    sd_clk_config u_clk_config (
        .clk_fast  (clk_fast),
        .arst_n    (arst_n),
        .cfg_req   (cfg_req),
        .cfg_speed (cfg_speed),
        .cfg_ack   (cfg_ack),
        .clk_idle  (clk_idle),
        .speed     (speed)
    );

    sd_clk_gen u_clk_gen (
        .clk_fast (clk_fast),
        .arst_n   (arst_n),
        .speed    (speed),
        .sd_clk   (sd_clk),
        .sd_rise  (sd_rise),
        .sd_fall  (sd_fall),
        .clk_idle (clk_idle)
    );

    // ========================================
    // Command path
    // ========================================
    sd_cmd_tx u_cmd_tx (
        .clk_fast     (clk_fast),
        .arst_n       (arst_n),
        .sd_fall      (sd_fall),
        .cmd_req      (cmd_req),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .cmd_resp_exp (cmd_resp_exp),
        .cmd_ack      (cmd_ack),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .rx_start     (rx_start),
        .rx_done      (rx_done),
        .rx_frame     (rx_frame),
        .rx_status    (rx_status),
        .resp_index   (resp_index),
        .resp_arg     (resp_arg),
        .resp_status  (resp_status)
    );

    sd_resp_rx u_resp_rx (
        .clk_fast  (clk_fast),
        .arst_n    (arst_n),
        .sd_rise   (sd_rise),
        .cmd_in    (cmd_in),
        .rx_start  (rx_start),
        .rx_done   (rx_done),
        .rx_frame  (rx_frame),
        .rx_status (rx_status)
    );

endmodule

// File: bench/sd_card_model.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module sd_card_model (
    input  logic                  sd_clk,
    input  logic                  cmd_out,
    input  logic                  cmd_oe,
    output logic                  cmd_in,
    input  logic                  bad_crc,
    input  logic                  mute,
    output sd_cmd_pkg::sd_frame_u last_frame,
    output logic                  last_crc_ok,
    output int                    frame_count
);
    import sd_cmd_pkg::*;

    localparam logic [31:0] resp_xor   = 32'hA5A5A5A5;
    localparam int          resp_delay = 4;

    // x^7 + x^3 + 1 over the covered bits, first bit on the line first
    function automatic logic [`SD_CRC_BITS-1:0] card_crc7(
        input logic [`SD_CRC_COVER_BITS-1:0] bits
    );
        logic [`SD_CRC_BITS-1:0] c;
        logic                    fb;
        int                      i;
        c = '0;
        for (i = `SD_CRC_COVER_BITS - 1; i >= 0; i--) begin
            fb = bits[i] ^ c[`SD_CRC_BITS-1];
            c  = {c[`SD_CRC_BITS-2:0], 1'b0};
            if (fb) begin
                c = c ^ 7'h09;
            end
        end
        return c;
    endfunction

    // Host bits are sampled on rising card clock edges while it drives the line
    task automatic capture_frame(output sd_frame_u frame);
        int taken;
        taken     = 0;
        frame.raw = '0;
        while (taken < `SD_FRAME_BITS) begin
            @(posedge sd_clk);
            if (cmd_oe) begin
                frame.raw = {frame.raw[`SD_FRAME_BITS-2:0], cmd_out};
                taken++;
            end
        end
    endtask

    task automatic send_response(input sd_frame_u cmd);
        sd_frame_u resp;
        int        i;
        resp.fields.start = 1'b0;
        resp.fields.dir   = 1'b0;
        resp.fields.index = cmd.fields.index;
        resp.fields.arg   = cmd.fields.arg ^ resp_xor;
        resp.fields.crc   = card_crc7(resp.raw[`SD_FRAME_BITS-1 -: `SD_CRC_COVER_BITS]);
        resp.fields.stop  = 1'b1;
        if (bad_crc) begin
            resp.fields.crc[0] = ~resp.fields.crc[0];
        end
        repeat (resp_delay) @(negedge sd_clk);
        for (i = `SD_FRAME_BITS - 1; i >= 0; i--) begin
            cmd_in <= resp.raw[i];
            @(negedge sd_clk);
        end
        cmd_in <= 1'b1;
    endtask

    // ========================================
    // Card behavior
    // ========================================
    initial begin : card_loop
        sd_frame_u cmd;
        cmd_in      <= 1'b1;
        last_frame  = '0;
        last_crc_ok = 1'b0;
        frame_count = 0;
        forever begin
            capture_frame(cmd);
            last_frame  = cmd;
            last_crc_ok = (card_crc7(cmd.raw[`SD_FRAME_BITS-1 -: `SD_CRC_COVER_BITS])
                           == cmd.fields.crc);
            frame_count = frame_count + 1;
            if (!mute) begin
                send_response(cmd);
            end
        end
    end

endmodule

// File: bench/tb_sd_cmd_host.sv
`timescale 1ns/1ps
`include "sd_settings.svh"

module tb_sd_cmd_host;
    import sd_clk_pkg::*;
    import sd_cmd_pkg::*;

    localparam int clk_period_ns = 40;
    localparam int reset_cycles  = 5;
    localparam int num_tests     = 5;

    // One frame at slow speed in ns
    localparam int frame_ns    = `SD_FRAME_BITS * 2 * `SD_SLOW_HALF * clk_period_ns;
    localparam int watchdog_ns = num_tests * 6 * frame_ns;

    localparam logic [31:0] resp_xor = 32'hA5A5A5A5;

    logic         clk_fast;
    logic         arst_n;
    logic         cfg_req;
    clk_speed_t   cfg_speed;
    logic         cfg_ack;
    logic         cmd_req;
    logic [5:0]   cmd_index;
    logic [31:0]  cmd_arg;
    logic         cmd_resp_exp;
    logic         cmd_ack;
    logic [5:0]   resp_index;
    logic [31:0]  resp_arg;
    resp_status_t resp_status;
    logic         sd_clk;
    logic         cmd_out;
    logic         cmd_oe;
    logic         cmd_in;

    // Card model knobs and observations
    logic         bad_crc;
    logic         mute;
    sd_frame_u    card_frame;
    logic         card_crc_ok;
    int           card_frames;

    logic [15:0]  lfsr_state;

    sd_cmd_host u_dut (
        .clk_fast     (clk_fast),
        .arst_n       (arst_n),
        .cfg_req      (cfg_req),
        .cfg_speed    (cfg_speed),
        .cfg_ack      (cfg_ack),
        .cmd_req      (cmd_req),
        .cmd_index    (cmd_index),
        .cmd_arg      (cmd_arg),
        .cmd_resp_exp (cmd_resp_exp),
        .cmd_ack      (cmd_ack),
        .resp_index   (resp_index),
        .resp_arg     (resp_arg),
        .resp_status  (resp_status),
        .sd_clk       (sd_clk),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .cmd_in       (cmd_in)
    );

    sd_card_model u_card (
        .sd_clk      (sd_clk),
        .cmd_out     (cmd_out),
        .cmd_oe      (cmd_oe),
        .cmd_in      (cmd_in),
        .bad_crc     (bad_crc),
        .mute        (mute),
        .last_frame  (card_frame),
        .last_crc_ok (card_crc_ok),
        .frame_count (card_frames)
    );

    initial begin
        clk_fast = 1'b0;
        forever #(clk_period_ns / 2) clk_fast = ~clk_fast;
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic abort_run(input string reason);
        $display("Stopping: %s", reason);
        $display("Done: errors found");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run("a DUT output did not match its expected value");
        end
    endtask

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] draw_bits(input int width);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < width; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [6:0] expected_crc7(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        int         i;
        c = '0;
        for (i = 39; i >= 0; i--) begin
            fb = bits[i] ^ c[6];
            c  = {c[5:0], 1'b0};
            if (fb) begin
                c = c ^ 7'b000_1001;
            end
        end
        return c;
    endfunction

    task automatic set_knobs(input logic crc_knob, input logic mute_knob);
        @(posedge clk_fast);
        bad_crc <= crc_knob;
        mute    <= mute_knob;
    endtask

    task automatic wait_cmd_ack(input logic level);
        @(negedge clk_fast);
        while (cmd_ack !== level) @(negedge clk_fast);
    endtask

    task automatic wait_cfg_ack(input logic level);
        @(negedge clk_fast);
        while (cfg_ack !== level) @(negedge clk_fast);
    endtask

    // Full four-phase command with results taken while cmd_ack is high
    task automatic run_command(
        input  logic [5:0]   index,
        input  logic [31:0]  arg,
        input  logic         resp_exp,
        output logic [5:0]   got_index,
        output logic [31:0]  got_arg,
        output resp_status_t got_status
    );
        @(posedge clk_fast);
        cmd_index    <= index;
        cmd_arg      <= arg;
        cmd_resp_exp <= resp_exp;
        cmd_req      <= 1'b1;
        wait_cmd_ack(1'b1);
        got_index  = resp_index;
        got_arg    = resp_arg;
        got_status = resp_status;
        @(posedge clk_fast);
        cmd_req <= 1'b0;
        wait_cmd_ack(1'b0);
    endtask

    // Response payload is meaningless after a timeout
    task automatic expect_response(input logic [5:0] index, input logic [31:0] arg,
                                   input resp_status_t exp_status);
        logic [5:0]   got_index;
        logic [31:0]  got_arg;
        resp_status_t got_status;
        run_command(index, arg, 1'b1, got_index, got_arg, got_status);
        check_value("card crc flag", 64'(card_crc_ok), 64'd1);
        check_value("resp_status", 64'(got_status), 64'(exp_status));
        if (exp_status != resp_timeout) begin
            check_value("resp_index", 64'(got_index), 64'(index));
            check_value("resp_arg", 64'(got_arg), 64'(arg ^ resp_xor));
        end
    endtask

    task automatic configure_speed(input clk_speed_t spd);
        @(posedge clk_fast);
        cfg_speed <= spd;
        cfg_req   <= 1'b1;
        wait_cfg_ack(1'b1);
        @(posedge clk_fast);
        cfg_req <= 1'b0;
        wait_cfg_ack(1'b0);
    endtask

    // clk_fast cycles between two rising edges of sd_clk
    task automatic measure_period(output int cycles);
        logic prev;
        int   edges;
        int   n;
        edges = 0;
        n     = 0;
        @(negedge clk_fast);
        prev = sd_clk;
        while (edges < 2) begin
            @(negedge clk_fast);
            if (edges == 1) begin
                n++;
            end
            if (sd_clk && !prev) begin
                edges++;
            end
            prev = sd_clk;
        end
        cycles = n;
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_no_response();
        logic [5:0]   index;
        logic [31:0]  arg;
        logic [5:0]   got_index;
        logic [31:0]  got_arg;
        resp_status_t got_status;
        int           frames_before;
        int           n;
        set_knobs(1'b0, 1'b1);
        for (n = 0; n < 2; n++) begin
            index         = 6'(draw_bits(6));
            arg           = draw_bits(32);
            frames_before = card_frames;
            check_value("cmd_ack", 64'(cmd_ack), 64'd0);
            run_command(index, arg, 1'b0, got_index, got_arg, got_status);
            check_value("card frame count", 64'(card_frames), 64'(frames_before + 1));
            check_value("frame start", 64'(card_frame.fields.start), 64'd0);
            check_value("frame dir", 64'(card_frame.fields.dir), 64'd1);
            check_value("frame index", 64'(card_frame.fields.index), 64'(index));
            check_value("frame arg", 64'(card_frame.fields.arg), 64'(arg));
            check_value("frame crc", 64'(card_frame.fields.crc),
                        64'(expected_crc7({1'b0, 1'b1, index, arg})));
            check_value("frame stop", 64'(card_frame.fields.stop), 64'd1);
        end
    endtask

    task automatic test_good_response();
        int n;
        set_knobs(1'b0, 1'b0);
        for (n = 0; n < 4; n++) begin
            expect_response(6'(draw_bits(6)), draw_bits(32), resp_ok);
        end
    endtask

    task automatic test_bad_crc();
        set_knobs(1'b1, 1'b0);
        expect_response(6'(draw_bits(6)), draw_bits(32), resp_crc_err);
        set_knobs(1'b0, 1'b0);
    endtask

    task automatic test_no_card_answer();
        set_knobs(1'b0, 1'b1);
        expect_response(6'(draw_bits(6)), draw_bits(32), resp_timeout);
        set_knobs(1'b0, 1'b0);
    endtask

    task automatic test_clock_config();
        int cycles;
        int n;
        // Reset leaves the slow rate selected
        measure_period(cycles);
        check_value("sd_clk period", 64'(cycles), 64'(2 * `SD_SLOW_HALF));

        configure_speed(speed_fast);
        measure_period(cycles);
        check_value("sd_clk period", 64'(cycles), 64'(2 * `SD_FAST_HALF));
        expect_response(6'(draw_bits(6)), draw_bits(32), resp_ok);

        configure_speed(speed_off);
        for (n = 0; n < 100; n++) begin
            @(negedge clk_fast);
            check_value("sd_clk", 64'(sd_clk), 64'd0);
        end

        configure_speed(speed_slow);
        measure_period(cycles);
        check_value("sd_clk period", 64'(cycles), 64'(2 * `SD_SLOW_HALF));
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin : main
        lfsr_state = 16'd17006;
        arst_n       <= 1'b0;
        cfg_req      <= 1'b0;
        cfg_speed    <= speed_slow;
        cmd_req      <= 1'b0;
        cmd_index    <= '0;
        cmd_arg      <= '0;
        cmd_resp_exp <= 1'b0;
        bad_crc      <= 1'b0;
        mute         <= 1'b0;
        repeat (reset_cycles) @(posedge clk_fast);
        arst_n <= 1'b1;
        repeat (2) @(posedge clk_fast);

        test_no_response();
        test_good_response();
        test_bad_crc();
        test_no_card_answer();
        test_clock_config();

        $display("Done: no errors");
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        abort_run("watchdog expired before the tests finished");
    end

endmodule

// File: sources.f
+incdir+verilog
verilog/sd_clk_pkg.sv
verilog/sd_cmd_pkg.sv
verilog/sd_crc7.sv
verilog/sd_clk_config.sv
verilog/sd_clk_gen.sv
verilog/sd_cmd_tx.sv
verilog/sd_resp_rx.sv
verilog/sd_cmd_host.sv
bench/sd_card_model.sv
bench/tb_sd_cmd_host.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the SD command path testbench with Verilator

ROOT="$(cd "$(dirname "$0")" && pwd)"
cd "$ROOT" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_sd_cmd_host \
    -Mdir obj_dir \
    -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit $status
fi

./obj_dir/Vtb_sd_cmd_host
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
